/* i2s_tone_top.f */
+incdir+src
src/i2s_tone_pkg.sv
src/i2s_clock_divider.sv
src/frame_sequencer.sv
src/wave_table.sv
src/sample_serializer.sv
src/i2s_tone_top.sv
testbench/i2s_tone_tb.sv

/* Bender.yml */
package:
  name: i2s_tone

sources:
  - include_dirs:
      - src
    files:
      - src/i2s_tone_pkg.sv
      - src/i2s_clock_divider.sv
      - src/frame_sequencer.sv
      - src/wave_table.sv
      - src/sample_serializer.sv
      - src/i2s_tone_top.sv

  - target: test
    include_dirs:
      - src
    files:
      - testbench/i2s_tone_tb.sv

/* testbench/i2s_tone_tb.sv */
`timescale 1ns/1ps
`default_nettype none

`include "i2s_tone_macros.svh"

module i2s_tone_tb
    import i2s_tone_pkg::*;
();

    localparam int wait_limit = 2100;  // clk cycles to cover more than two frames
    localparam int bit_limit  = 40;

    logic   clk;
    logic   reset;
    logic   enable;
    atten_t rshift;
    logic   mclk;
    logic   bclk;
    logic   lrclk;
    logic   sdata;

    integer seed;
    int     table_pos;  // table entry the next received frame should carry

    always #5 clk = ~clk;

    i2s_tone_top dut0
    (
        .clk    (clk),
        .reset  (reset),
        .enable (enable),
        .rshift (rshift),
        .mclk   (mclk),
        .bclk   (bclk),
        .lrclk  (lrclk),
        .sdata  (sdata)
    );

    function automatic sample_t table_entry(input int idx);
        sample_t sine_value;
        sine_value = '0;
        case (idx)
`include "sine_table.svh"
            default: sine_value = '0;
        endcase
        return sine_value;
    endfunction

    // attenuation as division by a power of two, rounded toward minus infinity
    function automatic sample_t expected_word(input int idx, input atten_t sh);
        longint value;
        longint step_size;
        longint quotient;
        value     = table_entry(idx);
        step_size = longint'(1) << sh;
        quotient  = value / step_size;
        if (value < 0 && quotient * step_size != value)
            quotient = quotient - 1;
        return sample_t'(quotient);
    endfunction

    function automatic logic clock_level(input int sel);
        case (sel)
            0:       return mclk;
            1:       return bclk;
            default: return lrclk;
        endcase
    endfunction

    task automatic fail_run();
        $display("Something failed");
        $fatal(1);
    endtask

    task automatic check_value(input string test_name, input logic [31:0] expected,
                               input logic [31:0] actual);
        assert (actual === expected)
        else
        begin
            $display("** Error [%s] expected 32'h%08h, actual 32'h%08h",
                     test_name, expected, actual);
            fail_run();
        end
    endtask

    task automatic report_timeout(input string what);
        $display("Timeout: no %s seen within the cycle limit", what);
        fail_run();
    endtask

    task automatic set_inputs(input logic en, input atten_t sh);
        @(posedge clk);
        #1;
        enable = en;
        rshift = sh;
    endtask

    task automatic wait_lrclk_edge(input logic level);
        logic prev;
        logic found;
        prev  = lrclk;
        found = 1'b0;
        for (int n = 0; !found; n++)
        begin
            if (n == wait_limit)
                report_timeout("lrclk edge");
            @(negedge clk);  // outputs settle at posedge
            found = (lrclk == level) && (prev != level);
            prev  = lrclk;
        end
    endtask

    task automatic wait_clock_rise(input int sel, output int cycles);
        logic prev;
        logic found;
        prev   = clock_level(sel);
        found  = 1'b0;
        cycles = 0;
        while (!found)
        begin
            if (cycles == wait_limit)
                report_timeout("clock rise");
            @(negedge clk);
            cycles++;
            found = clock_level(sel) && !prev;
            prev  = clock_level(sel);
        end
    endtask

    // bclk rises while lrclk stays at level
    task automatic count_bclk_in_half(input logic level, output int rises);
        logic prev;
        prev  = bclk;
        rises = 0;
        for (int n = 0; lrclk == level; n++)
        begin
            if (n == wait_limit)
                report_timeout("end of lrclk half");
            @(negedge clk);
            if (bclk && !prev && lrclk == level)
                rises++;
            prev = bclk;
        end
    endtask

    // receiver model shifts in one bit per bclk rise and checks the lrclk slot
    task automatic collect_bits(input string test_name, input int count,
                                input logic level, inout sample_t word);
        logic prev;
        logic found;
        prev = bclk;
        for (int b = 0; b < count; b++)
        begin
            found = 1'b0;
            for (int n = 0; !found; n++)
            begin
                if (n == bit_limit)
                    report_timeout("bclk rise");
                @(negedge clk);
                found = bclk && !prev;
                prev  = bclk;
            end
            check_value({test_name, " slot"}, level, lrclk);
            word = {word[`I2S_SAMPLE_W-2:0], sdata};
        end
    endtask

    task automatic check_frame(input string test_name, input sample_t expected_left,
                               input sample_t expected_right);
        sample_t left;
        sample_t right;
        left  = '0;
        right = '0;
        wait_lrclk_edge(1'b0);  // left slot starts as lrclk falls
        collect_bits(test_name, `I2S_SAMPLE_W, 1'b0, left);
        collect_bits(test_name, `I2S_SAMPLE_W, 1'b1, right);
        check_value({test_name, " left"}, expected_left, left);
        check_value({test_name, " right"}, expected_right, right);
    endtask

    task automatic verify_reset_and_clocks();
        int cycles;
        int rises;
        repeat (4)
        begin
            @(posedge clk);
            #1;
            check_value("reset", 0, {sdata, mclk, bclk, lrclk});
        end
        reset = 1'b0;
        @(negedge clk);
        check_value("reset release", 0, {sdata, mclk, bclk, lrclk});

        wait_clock_rise(0, cycles);
        wait_clock_rise(0, cycles);
        check_value("mclk period", 4, cycles);
        wait_clock_rise(1, cycles);
        wait_clock_rise(1, cycles);
        check_value("bclk period", 16, cycles);
        wait_clock_rise(2, cycles);
        wait_clock_rise(2, cycles);
        check_value("lrclk period", 1024, cycles);

        wait_lrclk_edge(1'b1);
        count_bclk_in_half(1'b1, rises);
        check_value("bclk per right half", 32, rises);
        count_bclk_in_half(1'b0, rises);
        check_value("bclk per left half", 32, rises);
    endtask

    task automatic play_tone();
        table_pos = 0;
        set_inputs(1'b1, '0);
        for (int k = 0; k < 100; k++)
        begin
            check_frame("tone", expected_word(table_pos, 0), expected_word(table_pos, 0));
            table_pos = (table_pos + 1) % `I2S_TABLE_LEN;
        end
    endtask

    task automatic sweep_attenuation();
        atten_t sh;
        for (int v = 0; v < 5; v++)
        begin
            sh = atten_t'($random(seed));
            set_inputs(1'b1, sh);  // lands before the next left load
            repeat (3)
            begin
                check_frame("attenuation", expected_word(table_pos, sh),
                            expected_word(table_pos, sh));
                table_pos = (table_pos + 1) % `I2S_TABLE_LEN;
            end
        end
    endtask

    task automatic stop_and_restart();
        set_inputs(1'b0, '0);
        repeat (3)
            check_frame("silence", '0, '0);
        set_inputs(1'b1, '0);
        table_pos = 0;
        repeat (2)
        begin
            check_frame("restart", expected_word(table_pos, 0), expected_word(table_pos, 0));
            table_pos = (table_pos + 1) % `I2S_TABLE_LEN;
        end
    endtask

    task automatic change_shift_mid_slot();
        sample_t left;
        sample_t right;
        left  = '0;
        right = '0;
        wait_lrclk_edge(1'b0);
        collect_bits("late shift", 16, 1'b0, left);
        set_inputs(1'b1, 4'd5);
        collect_bits("late shift", 16, 1'b0, left);
        collect_bits("late shift", `I2S_SAMPLE_W, 1'b1, right);
        check_value("late shift left", expected_word(table_pos, 0), left);
        check_value("late shift right", expected_word(table_pos, 5), right);
        table_pos = (table_pos + 1) % `I2S_TABLE_LEN;
        check_frame("late shift next", expected_word(table_pos, 5), expected_word(table_pos, 5));
    endtask

    initial
    begin
        clk       = 1'b0;
        reset     = 1'b1;
        enable    = 1'b0;
        rshift    = '0;
        seed      = 32'h5041;
        table_pos = 0;

        verify_reset_and_clocks();
        play_tone();
        sweep_attenuation();
        stop_and_restart();
        change_shift_mid_slot();

        $display("Everything OK");
        $finish;
    end

endmodule

`default_nettype wire

/* src/i2s_tone_top.sv */
`timescale 1ns/1ps
`default_nettype none

module i2s_tone_top
    import i2s_tone_pkg::*;
(
    input  wire logic   clk,
    input  wire logic   reset,
    input  wire logic   enable,
    input  wire atten_t rshift,
    output logic        mclk,
    output logic        bclk,
    output logic        lrclk,
    output logic        sdata
);

    i2s_clocks_t   clocks;
    timing_ticks_t ticks;
    logic          load_sample;
    logic          load_silence;
    logic          step;
    logic          restart;
    sample_t       sample;

    i2s_clock_divider divider0
    (
        .clk    (clk),
        .reset  (reset),
        .clocks (clocks),
        .ticks  (ticks)
    );

    frame_sequencer sequencer0
    (
        .clk          (clk),
        .reset        (reset),
        .enable       (enable),
        .ticks        (ticks),
        .load_sample  (load_sample),
        .load_silence (load_silence),
        .step         (step),
        .restart      (restart)
    );

    wave_table wave0
    (
        .clk     (clk),
        .reset   (reset),
        .step    (step),
        .restart (restart),
        .sample  (sample)
    );

    sample_serializer serializer0
    (
        .clk          (clk),
        .reset        (reset),
        .ticks        (ticks),
        .load_sample  (load_sample),
        .load_silence (load_silence),
        .sample       (sample),
        .rshift       (rshift),
        .sdata        (sdata)
    );

    assign mclk  = clocks.mclk;
    assign bclk  = clocks.bclk;
    assign lrclk = clocks.lrclk;

endmodule

`default_nettype wire

/* src/sample_serializer.sv */
`timescale 1ns/1ps
`default_nettype none

`include "i2s_tone_macros.svh"

module sample_serializer
    import i2s_tone_pkg::*;
(
    input  wire logic          clk,
    input  wire logic          reset,
    input  wire timing_ticks_t ticks,
    input  wire logic          load_sample,
    input  wire logic          load_silence,
    input  wire sample_t       sample,
    input  wire atten_t        rshift,
    output logic               sdata
);

    sample_t shifter;

    // load wins over the bit shift that falls on the same cycle
    always_ff @(posedge clk or posedge reset)
    begin
        if (reset)
        begin
            shifter <= '0;
        end
        else if (load_sample)
        begin
            shifter <= sample >>> rshift;  // sign kept
        end
        else if (load_silence)
        begin
            shifter <= '0;
        end
        else if (ticks.bit_tick)
        begin
            shifter <= shifter << 1;  // zeros fill from the bottom
        end
    end

    assign sdata = shifter[`I2S_SAMPLE_W-1];

    assert property (@(posedge clk) disable iff (reset)
        load_silence |=> !sdata);

endmodule

`default_nettype wire

/* src/wave_table.sv */
`timescale 1ns/1ps
`default_nettype none

`include "i2s_tone_macros.svh"

module wave_table
    import i2s_tone_pkg::*;
(
    input  wire logic clk,
    input  wire logic reset,
    input  wire logic step,
    input  wire logic restart,
    output sample_t   sample
);

    table_index_t index;
    sample_t      sine_value;

    always_ff @(posedge clk or posedge reset)
    begin
        if (reset)
            index <= '0;
        else if (restart)
            index <= '0;
        else if (step)
            index <= (index == table_index_t'(`I2S_TABLE_LEN - 1)) ? '0 : index + 1'b1;
    end

    always_comb
    begin
        case (index)
`include "sine_table.svh"
            default: sine_value = '0;  // unreachable past 47
        endcase
    end

    assign sample = sine_value;

    assert property (@(posedge clk) disable iff (reset)
        index < `I2S_TABLE_LEN);

endmodule

`default_nettype wire

/* src/frame_sequencer.sv */
`timescale 1ns/1ps
`default_nettype none

module frame_sequencer
    import i2s_tone_pkg::*;
(
    input  wire logic          clk,
    input  wire logic          reset,
    input  wire logic          enable,
    input  wire timing_ticks_t ticks,
    output logic               load_sample,
    output logic               load_silence,
    output logic               step,
    output logic               restart
);

    seq_state_t state;
    seq_state_t state_next;

    always_ff @(posedge clk or posedge reset)
    begin
        if (reset)
            state <= st_idle;
        else
            state <= state_next;
    end

    // loads are combinational so the new word is in the shifter as lrclk toggles
    always_comb
    begin
        state_next   = state;
        load_sample  = 1'b0;
        load_silence = 1'b0;
        step         = 1'b0;
        restart      = 1'b0;

        case (state)
            st_idle:
                if (ticks.frame_tick)
                begin
                    if (enable)
                    begin
                        load_sample = 1'b1;  // entry 0 goes out first
                        state_next  = st_left;
                    end
                    else
                    begin
                        load_silence = 1'b1;
                        restart      = 1'b1;
                    end
                end
                else if (ticks.half_tick)
                begin
                    load_silence = 1'b1;
                end

            st_left:
                if (ticks.half_tick)
                begin
                    // right word repeats the entry, then the index moves on
                    load_sample = 1'b1;
                    step        = 1'b1;
                    state_next  = st_right;
                end

            default:
                if (ticks.frame_tick)
                begin
                    if (enable)
                    begin
                        load_sample = 1'b1;
                        state_next  = st_left;
                    end
                    else
                    begin
                        load_silence = 1'b1;
                        restart      = 1'b1;
                        state_next   = st_idle;
                    end
                end
        endcase
    end

    assert property (@(posedge clk) disable iff (reset)
        !(load_sample && load_silence));

    assert property (@(posedge clk) disable iff (reset)
        step |-> load_sample);

    // playback stops on the frame boundary after enable drops
    assert property (@(posedge clk) disable iff (reset)
        (ticks.frame_tick && !enable) |=> state == st_idle);

endmodule

`default_nettype wire

/* src/i2s_clock_divider.sv */
`timescale 1ns/1ps
`default_nettype none

`include "i2s_tone_macros.svh"

module i2s_clock_divider
    import i2s_tone_pkg::*;
(
    input  wire logic    clk,
    input  wire logic    reset,
    output i2s_clocks_t   clocks,
    output timing_ticks_t ticks
);

    logic [`I2S_DIV_W-1:0] div_cnt;
    logic [`I2S_DIV_W-1:0] div_next;

    assign div_next = div_cnt + 1'b1;

    always_ff @(posedge clk or posedge reset)
    begin
        if (reset)
        begin
            div_cnt <= '0;
        end
        else
        begin
            div_cnt <= div_next;
        end
    end

    // decoded from the next count so each strobe lands on the all-ones cycle
    always_ff @(posedge clk or posedge reset)
    begin
        if (reset)
        begin
            ticks <= '0;
        end
        else
        begin
            ticks.bit_tick   <= &div_next[`I2S_BCLK_BIT:0];
            ticks.half_tick  <= &div_next[`I2S_LRCLK_BIT-1:0] & ~div_next[`I2S_LRCLK_BIT];
            ticks.frame_tick <= &div_next[`I2S_LRCLK_BIT:0];
        end
    end

    assign clocks = '{
        mclk:  div_cnt[`I2S_MCLK_BIT],
        bclk:  div_cnt[`I2S_BCLK_BIT],
        lrclk: div_cnt[`I2S_LRCLK_BIT]
    };

    // slot boundaries must never merge
    assert property (@(posedge clk) disable iff (reset)
        !(ticks.half_tick && ticks.frame_tick));

    // the frame strobe is the last cycle before lrclk falls
    assert property (@(posedge clk) disable iff (reset)
        ticks.frame_tick |-> clocks.lrclk ##1 !clocks.lrclk);

endmodule

`default_nettype wire

/* src/i2s_tone_pkg.sv */
`default_nettype none

`include "i2s_tone_macros.svh"

package i2s_tone_pkg;

    typedef logic signed [`I2S_SAMPLE_W-1:0] sample_t;

    typedef logic [`I2S_INDEX_W-1:0] table_index_t;

    typedef logic [`I2S_SHIFT_W-1:0] atten_t;  // right-shift amount

    // pin-level clocks straight from the divider taps
    typedef struct packed
    {
        logic mclk;
        logic bclk;
        logic lrclk;
    } i2s_clocks_t;

    // one-cycle strobes each in the last clk of its period
    typedef struct packed
    {
        logic bit_tick;
        logic half_tick;   // end of left slot
        logic frame_tick;  // end of right slot
    } timing_ticks_t;

    typedef enum logic [1:0]
    {
        st_idle,
        st_left,
        st_right
    } seq_state_t;

endpackage

`default_nettype wire

/* src/i2s_tone_macros.svh */
`ifndef I2S_TONE_MACROS_SVH
`define I2S_TONE_MACROS_SVH

// audio word
`define I2S_SAMPLE_W 32

// one table entry per stereo frame
`define I2S_TABLE_LEN 48
`define I2S_INDEX_W 6

// attenuation as arithmetic right shift
`define I2S_SHIFT_W 4

// 50 MHz / 1024 gives the 48.8 kHz frame rate
`define I2S_DIV_W 10

// divider taps for the three clocks
`define I2S_MCLK_BIT 1   // clk / 4
`define I2S_BCLK_BIT 3   // clk / 16
`define I2S_LRCLK_BIT 9  // clk / 1024

`endif

/* src/sine_table.svh */
0: sine_value = 32'sd0;
1: sine_value = 32'sd280302864;
2: sine_value = 32'sd555809651;
3: sine_value = 32'sd821806413;
4: sine_value = 32'sd1073741824;
5: sine_value = 32'sd1307305217;
6: sine_value = 32'sd1518500249;
7: sine_value = 32'sd1703713328;
8: sine_value = 32'sd1859775393;
9: sine_value = 32'sd1984016188;
10: sine_value = 32'sd2074309917;
11: sine_value = 32'sd2129111626;
12: sine_value = 32'sd2147483647;
13: sine_value = 32'sd2129111626;
14: sine_value = 32'sd2074309917;
15: sine_value = 32'sd1984016188;
16: sine_value = 32'sd1859775393;
17: sine_value = 32'sd1703713328;
18: sine_value = 32'sd1518500249;
19: sine_value = 32'sd1307305217;
20: sine_value = 32'sd1073741824;
21: sine_value = 32'sd821806413;
22: sine_value = 32'sd555809651;
23: sine_value = 32'sd280302864;
24: sine_value = 32'sd0;
25: sine_value = -32'sd280302864;
26: sine_value = -32'sd555809651;
27: sine_value = -32'sd821806413;
28: sine_value = -32'sd1073741824;
29: sine_value = -32'sd1307305217;
30: sine_value = -32'sd1518500249;
31: sine_value = -32'sd1703713328;
32: sine_value = -32'sd1859775393;
33: sine_value = -32'sd1984016188;
34: sine_value = -32'sd2074309917;
35: sine_value = -32'sd2129111626;
36: sine_value = -32'sd2147483647;
37: sine_value = -32'sd2129111626;
38: sine_value = -32'sd2074309917;
39: sine_value = -32'sd1984016188;
40: sine_value = -32'sd1859775393;
41: sine_value = -32'sd1703713328;
42: sine_value = -32'sd1518500249;
43: sine_value = -32'sd1307305217;
44: sine_value = -32'sd1073741824;
45: sine_value = -32'sd821806413;
46: sine_value = -32'sd555809651;
47: sine_value = -32'sd280302864;
